//--- list.f
verilog/csi2_pkg.sv
verilog/csi2_dec_if.sv
verilog/csi2_byte_packer.sv
verilog/csi2_hamming_dec.sv
verilog/csi2_header_parse.sv
verilog/csi2_rx_header_top.sv
testbench/tb_csi2_rx_header.sv

//--- testbench/tb_csi2_rx_header.sv
`timescale 1ns/1ps

module tb_csi2_rx_header;

localparam int PKT_COUNT   = 19;
localparam int TOTAL_BYTES = 3*8 + 5*4 + 4*12 + ( 5 + 8 + 11 + 17 + 16 ) + 2*4;
localparam int WATCHDOG_NS = ( TOTAL_BYTES + 20 * PKT_COUNT ) * 10 * 2;

logic          clk;
logic          srst;
logic          byte_valid;
logic [7 : 0]  byte_data;
logic          pkt_end;
logic          hdr_valid;
logic [1 : 0]  vc;
logic [5 : 0]  dt;
logic [15 : 0] wc;
logic          ecc_err;
logic          ecc_fixed;
logic          pay_valid;
logic [31 : 0] pay_data;
logic          pay_last;

int            cyc    = 0;
int            hdr_wr = 0;
int            hdr_rd = 0;
int            pay_wr = 0;
int            pay_rd = 0;
logic [15 : 0] lfsr   = 16'd11623;
int            fix_bits [5] = '{ 0, 7, 12, 19, 23 };

// Header entries hold { wc, vc, dt, ecc_err, ecc_fixed } and payload entries { last, data }.
logic [25 : 0] exp_hdr  [0 : 31];
int            hdr_cyc  [0 : 31];
string         hdr_name [0 : 31];
logic [32 : 0] exp_pay  [0 : 63];
int            pay_cyc  [0 : 63];
string         pay_name [0 : 63];

csi2_rx_header_top dut_i
(
  .clk_i        ( clk        ),
  .srst_i       ( srst       ),
  .byte_valid_i ( byte_valid ),
  .byte_i       ( byte_data  ),
  .pkt_end_i    ( pkt_end    ),
  .hdr_valid_o  ( hdr_valid  ),
  .vc_o         ( vc         ),
  .dt_o         ( dt         ),
  .wc_o         ( wc         ),
  .ecc_err_o    ( ecc_err    ),
  .ecc_fixed_o  ( ecc_fixed  ),
  .pay_valid_o  ( pay_valid  ),
  .pay_data_o   ( pay_data   ),
  .pay_last_o   ( pay_last   )
);

initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

always @( posedge clk )
  cyc <= cyc + 1;

// Consume one expected entry per strobe.
always @( posedge clk )
  if( !srst )
    begin
      if( hdr_valid )
        hdr_rd <= hdr_rd + 1;
      if( pay_valid )
        pay_rd <= pay_rd + 1;
    end

//////////////////////////////////////////////////
// Models and helpers.
//////////////////////////////////////////////////

function automatic logic [31 : 0] rand_bits( input int n );
  logic [31 : 0] v;
  v = 32'd0;
  for( int i = 0; i < n; i++ )
    begin
      v    = { v[30 : 0], lfsr[0] };
      lfsr = lfsr[0] ? ( lfsr >> 1 ) ^ 16'hB400 : lfsr >> 1;
    end
  return v;
endfunction

// Header ECC parity equations.
function automatic logic [5 : 0] ecc_bits( input logic [23 : 0] d );
  logic [5 : 0] p;
  p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
  p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
  p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
  p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
  p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
  p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
  return p;
endfunction

task automatic halt_run();
  $display( "STATUS: FAIL" );
  $fatal( 1, "Simulation stopped at the first error." );
endtask

task automatic report_error( input string msg );
  $display( "ERROR: %s", msg );
  halt_run();
endtask

task automatic report_mismatch( input string test, input string what,
                                input logic [63 : 0] exp, input logic [63 : 0] act );
  $display( "CHECK FAILED %s %s: expected %h, actual %h", test, what, exp, act );
  halt_run();
endtask

// Sends one packet with an optional bit flip mask over header bits 29:0.
task automatic send_packet( input string name, input logic is_long, input logic [15 : 0] wc_fix,
                            input logic [29 : 0] flip, input int tail );
  logic [1 : 0]  h_vc;
  logic [5 : 0]  h_dt;
  logic [15 : 0] h_wc;
  logic [23 : 0] d;
  logic [31 : 0] hdr;
  logic [31 : 0] wbuf;
  logic [7 : 0]  b;
  logic          fixable;
  logic          uncorr;
  logic          fwd;
  int            nbytes;
  int            nwords;
  int            j;
  h_vc    = 2'( rand_bits( 2 ) );
  h_dt    = is_long ? 6'( rand_bits( 6 ) ) | csi2_pkg::LONG_DT_MIN : 6'( rand_bits( 4 ) );
  h_wc    = is_long ? wc_fix : 16'( rand_bits( 16 ) );
  d       = { h_wc, h_vc, h_dt };
  hdr     = { 2'b00, ecc_bits( d ), d } ^ { 2'b00, flip };
  fixable = ( $countones( flip ) == 1 ) && ( flip[29 : 24] == 6'd0 );
  uncorr  = ( flip != 30'd0 ) && !fixable;
  fwd     = is_long && !uncorr;
  nbytes  = 4 + ( is_long ? h_wc : 0 ) + tail;
  nwords  = ( h_wc + 3 ) / 4;
  wbuf    = 32'd0;
  for( int i = 0; i < nbytes; i++ )
    begin
      b = ( i < 4 ) ? hdr[8*i +: 8] : 8'( rand_bits( 8 ) );
      @( posedge clk );
      #1;
      byte_valid             = 1'b1;
      byte_data              = b;
      pkt_end                = ( i == nbytes - 1 );
      wbuf[8*( i % 4 ) +: 8] = b;
      if( i % 4 == 3 || i == nbytes - 1 )
        begin
          j = ( i - 4 ) / 4;
          if( i < 4 )
            begin
              exp_hdr[hdr_wr]  = { uncorr ? hdr[23 : 0] : d, uncorr, fixable };
              hdr_cyc[hdr_wr]  = cyc;
              hdr_name[hdr_wr] = name;
              hdr_wr++;
            end
          else if( fwd && j < nwords )
            begin
              exp_pay[pay_wr]  = { j == nwords - 1, wbuf }; // Unsent bytes stay zero.
              pay_cyc[pay_wr]  = cyc;
              pay_name[pay_wr] = name;
              pay_wr++;
            end
          wbuf = 32'd0;
        end
    end
  @( posedge clk );
  #1;
  byte_valid = 1'b0;
  pkt_end    = 1'b0;
  repeat( 7 ) @( posedge clk ); // Longer than the 4-cycle path.
  if( hdr_rd != hdr_wr )
    report_error( $sformatf( "%s: header strobe missing", name ) );
  if( pay_rd != pay_wr )
    report_error( $sformatf( "%s: %0d of %0d payload strobes seen", name, pay_rd, pay_wr ) );
endtask

//////////////////////////////////////////////////
// Stimulus and watchdog.
//////////////////////////////////////////////////

initial
  begin
    srst       = 1'b1;
    byte_valid = 1'b0;
    byte_data  = 8'd0;
    pkt_end    = 1'b0;
    repeat( 3 ) @( posedge clk );
    #1;
    srst = 1'b0;
    for( int n = 0; n < 3; n++ )
      send_packet( "clean_short", 1'b0, 16'd0, 30'd0, 4 ); // Trailing word is not forwarded.
    foreach( fix_bits[n] )
      send_packet( "data_bit_fix", 1'b0, 16'd0, 30'd1 << fix_bits[n], 0 );
    send_packet( "parity_or_double", 1'b1, 16'd8, 30'd1 << 24, 0 );
    send_packet( "parity_or_double", 1'b1, 16'd8, 30'd1 << 29, 0 );
    send_packet( "parity_or_double", 1'b1, 16'd8, ( 30'd1 << 9 ) | ( 30'd1 << 20 ), 0 );
    send_packet( "parity_or_double", 1'b1, 16'd8, ( 30'd1 << 12 ) | ( 30'd1 << 17 ), 0 );
    send_packet( "long_payload", 1'b1, 16'd1, 30'd0, 0 );
    send_packet( "long_payload", 1'b1, 16'd4, 30'd0, 0 );
    send_packet( "long_payload", 1'b1, 16'd7, 30'd0, 0 );
    send_packet( "long_payload", 1'b1, 16'd13, 30'd0, 0 );
    send_packet( "long_payload", 1'b1, 16'd8, 30'd0, 4 );  // Trailing word is dropped.
    send_packet( "flag_clear", 1'b0, 16'd0, 30'd1 << 9, 0 );
    send_packet( "flag_clear", 1'b0, 16'd0, 30'd0, 0 );
    $display( "STATUS: PASS" );
    $finish;
  end

initial
  begin
    #( WATCHDOG_NS );
    report_error( "watchdog expired before all packets were checked" );
  end

//////////////////////////////////////////////////
// Output checks.
//////////////////////////////////////////////////

hdr_pending_a: assert property (
  @( posedge clk ) disable iff( srst ) hdr_valid |-> hdr_rd < hdr_wr
) else report_error( "header strobe with no packet pending" );

hdr_value_a: assert property (
  @( posedge clk ) disable iff( srst )
    ( hdr_valid && hdr_rd < hdr_wr ) |-> { wc, vc, dt, ecc_err, ecc_fixed } == exp_hdr[hdr_rd]
) else report_mismatch( hdr_name[$sampled( hdr_rd )], "header", exp_hdr[$sampled( hdr_rd )],
                        $sampled( { wc, vc, dt, ecc_err, ecc_fixed } ) );

hdr_latency_a: assert property (
  @( posedge clk ) disable iff( srst )
    ( hdr_valid && hdr_rd < hdr_wr ) |-> cyc == hdr_cyc[hdr_rd] + 4
) else report_mismatch( hdr_name[$sampled( hdr_rd )], "header cycle",
                        hdr_cyc[$sampled( hdr_rd )] + 4, $sampled( cyc ) );

pay_pending_a: assert property (
  @( posedge clk ) disable iff( srst ) pay_valid |-> pay_rd < pay_wr
) else report_error( "payload strobe with no payload word pending" );

pay_value_a: assert property (
  @( posedge clk ) disable iff( srst )
    ( pay_valid && pay_rd < pay_wr ) |-> { pay_last, pay_data } == exp_pay[pay_rd]
) else report_mismatch( pay_name[$sampled( pay_rd )], "payload", exp_pay[$sampled( pay_rd )],
                        $sampled( { pay_last, pay_data } ) );

pay_latency_a: assert property (
  @( posedge clk ) disable iff( srst )
    ( pay_valid && pay_rd < pay_wr ) |-> cyc == pay_cyc[pay_rd] + 4
) else report_mismatch( pay_name[$sampled( pay_rd )], "payload cycle",
                        pay_cyc[$sampled( pay_rd )] + 4, $sampled( cyc ) );

endmodule

//--- verilog/csi2_byte_packer.sv
`timescale 1ns/1ps

module csi2_byte_packer
(
  input                                 clk_i,
  input                                 srst_i,
  input                                 byte_valid_i,
  input        [7 : 0]                  byte_i,
  input                                 pkt_end_i,
  output logic                          word_valid_o,
  output logic [csi2_pkg::WORD_W-1 : 0] word_data_o,
  output logic                          pkt_done_o
);

logic [1 : 0]                  lane;
logic [csi2_pkg::WORD_W-1 : 0] shreg;
logic [csi2_pkg::WORD_W-1 : 0] shifted;
logic                          emit;
logic                          end_q;
logic                          end_d;

// New bytes enter at the top, so the oldest byte ends up in bits 7:0.
assign shifted = { byte_i, shreg[csi2_pkg::WORD_W-1 : 8] };
assign emit    = byte_valid_i && ( pkt_end_i || lane == 2'd3 );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    lane <= 2'd0;
  else
    if( byte_valid_i )
      lane <= pkt_end_i ? 2'd0 : lane + 2'd1;

always_ff @( posedge clk_i )
  if( byte_valid_i )
    shreg <= shifted;

// Stale bytes shift out of a partial word and zeros fill the top.
always_ff @( posedge clk_i )
  if( emit )
    word_data_o <= shifted >> ( 8 * ( 3 - lane ) );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      word_valid_o <= 1'b0;
      end_q        <= 1'b0;
      end_d        <= 1'b0;
      pkt_done_o   <= 1'b0;
    end
  else
    begin
      word_valid_o <= emit;
      end_q        <= byte_valid_i && pkt_end_i; // Marks the last word.
      end_d        <= end_q;
      pkt_done_o   <= end_d;
    end

//////////////////////////////////////////////////
// Source rules.
//////////////////////////////////////////////////

// The done pulse needs quiet input behind a packet.
idle_gap_a: assert property (
  @( posedge clk_i ) disable iff( srst_i )
    ( byte_valid_i && pkt_end_i ) |=> !byte_valid_i [*4]
);

endmodule

//--- verilog/csi2_dec_if.sv
`timescale 1ns/1ps

interface csi2_dec_if;

  logic                            valid;
  logic [csi2_pkg::WORD_W-1 : 0]   data;
  logic                            error;           // Header had a nonzero syndrome.
  logic                            error_corrected;
  logic                            header_valid;    // Header word in the delay stage.

  modport src
  (
    output valid, data, error, error_corrected, header_valid
  );

  modport dst
  (
    input valid, data, error, error_corrected, header_valid
  );

endinterface

//--- verilog/csi2_hamming_dec.sv
`timescale 1ns/1ps

module csi2_hamming_dec
(
  input                                 clk_i,
  input                                 srst_i,
  input                                 valid_i,
  input        [csi2_pkg::WORD_W-1 : 0] data_i,
  input                                 pkt_done_i,
  csi2_dec_if.src                       dec_o
);

logic [5 : 0]                  parity;
logic [5 : 0]                  syndrome;
logic [4 : 0]                  err_pos;
logic                          syn_nz;
logic [csi2_pkg::WORD_W-1 : 0] data_d;
logic                          valid_d;
logic                          header_passed;
logic                          header_valid;
logic                          hdr_err;
logic                          fix;

//////////////////////////////////////////////////
// Syndrome stage.
//////////////////////////////////////////////////

always_comb
  for( int j = 0; j < 6; j++ )
    parity[j] = ^( data_i[23 : 0] & csi2_pkg::PARITY_MASK[j] );

assign syndrome = parity ^ data_i[29 : 24];

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    syn_nz <= 1'b0;
  else
    syn_nz <= ( syndrome != 6'd0 );

always_ff @( posedge clk_i )
  err_pos <= csi2_pkg::ROM_INIT[syndrome];

always_ff @( posedge clk_i )
  data_d <= data_i;

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    valid_d <= 1'b0;
  else
    if( pkt_done_i )
      valid_d <= 1'b0;
    else
      valid_d <= valid_i;

//////////////////////////////////////////////////
// Header tracking.
//////////////////////////////////////////////////

// First word of the packet only.
assign header_valid       = valid_d && !header_passed && !pkt_done_i;
assign dec_o.header_valid = header_valid;

assign hdr_err = header_valid && syn_nz;
assign fix     = hdr_err && ( err_pos != csi2_pkg::NO_FIX_POS );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    header_passed <= 1'b0;
  else
    if( pkt_done_i )
      header_passed <= 1'b0;
    else
      if( header_valid )
        header_passed <= 1'b1;

//////////////////////////////////////////////////
// Output stage.
//////////////////////////////////////////////////

// Flags hold for the rest of the packet.
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      dec_o.error           <= 1'b0;
      dec_o.error_corrected <= 1'b0;
    end
  else
    if( pkt_done_i )
      begin
        dec_o.error           <= 1'b0;
        dec_o.error_corrected <= 1'b0;
      end
    else
      begin
        if( hdr_err )
          dec_o.error <= 1'b1;
        if( fix )
          dec_o.error_corrected <= 1'b1;
      end

// Position is below 24 whenever fix is set.
always_ff @( posedge clk_i )
  dec_o.data <= data_d ^ ( fix ? ( 32'd1 << err_pos ) : 32'd0 );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    dec_o.valid <= 1'b0;
  else
    if( pkt_done_i )
      dec_o.valid <= 1'b0;
    else
      dec_o.valid <= valid_d;

corr_needs_err_a: assert property (
  @( posedge clk_i ) disable iff( srst_i )
    dec_o.error_corrected |-> dec_o.error
);

endmodule

//--- verilog/csi2_header_parse.sv
`timescale 1ns/1ps

module csi2_header_parse
(
  input                                 clk_i,
  input                                 srst_i,
  csi2_dec_if.dst                       dec_i,
  output logic                          hdr_valid_o,
  output logic [1 : 0]                  vc_o,
  output logic [5 : 0]                  dt_o,
  output logic [15 : 0]                 wc_o,
  output logic                          ecc_err_o,
  output logic                          ecc_fixed_o,
  output logic                          pay_valid_o,
  output logic [csi2_pkg::WORD_W-1 : 0] pay_data_o,
  output logic                          pay_last_o
);

logic          hdr_q;    // Header word is at the decoder output.
logic          active;
logic [15 : 0] remain;
logic          uncorr;
logic          is_long;
logic          last_word;

assign uncorr    = dec_i.error && !dec_i.error_corrected;
assign is_long   = ( dec_i.data[5 : 0] >= csi2_pkg::LONG_DT_MIN );
assign last_word = ( remain <= 16'd4 );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      hdr_q       <= 1'b0;
      hdr_valid_o <= 1'b0;
      ecc_err_o   <= 1'b0;
      ecc_fixed_o <= 1'b0;
      active      <= 1'b0;
      pay_valid_o <= 1'b0;
      pay_last_o  <= 1'b0;
    end
  else
    begin
      hdr_q       <= dec_i.header_valid;
      hdr_valid_o <= hdr_q;
      pay_valid_o <= 1'b0;
      pay_last_o  <= 1'b0;
      if( hdr_q )
        begin
          ecc_err_o   <= uncorr;
          ecc_fixed_o <= dec_i.error_corrected;
          active      <= is_long && !uncorr && ( dec_i.data[23 : 8] != 16'd0 );
        end
      else
        if( active && dec_i.valid )
          begin
            pay_valid_o <= 1'b1;
            pay_last_o  <= last_word;
            active      <= !last_word; // Padding words are dropped.
          end
    end

// Header fields and the byte countdown.
always_ff @( posedge clk_i )
  if( hdr_q )
    begin
      vc_o   <= dec_i.data[7 : 6];
      dt_o   <= dec_i.data[5 : 0];
      wc_o   <= dec_i.data[23 : 8];
      remain <= dec_i.data[23 : 8];
    end
  else
    if( dec_i.valid )
      remain <= remain - 16'd4;

always_ff @( posedge clk_i )
  if( dec_i.valid )
    pay_data_o <= dec_i.data;

last_in_valid_a: assert property (
  @( posedge clk_i ) disable iff( srst_i )
    pay_last_o |-> pay_valid_o
);

endmodule

//--- verilog/csi2_pkg.sv
package csi2_pkg;

  localparam int WORD_W = 32;

  // Position marker for syndromes that point at no data bit.
  localparam logic [4 : 0] NO_FIX_POS = 5'd31;

  // Data types from here up carry a payload.
  localparam logic [5 : 0] LONG_DT_MIN = 6'h10;

  //////////////////////////////////////////////////
  // ECC coverage of header data bits 23:0.
  //////////////////////////////////////////////////

  localparam logic [5 : 0][23 : 0] PARITY_MASK = {
    24'hEFFC00, // P5.
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7  // P0.
  };

  // The parity column of data bit k, read as a syndrome, maps back to k.
  function automatic logic [63 : 0][4 : 0] build_rom();
    logic [63 : 0][4 : 0] rom;
    logic [5 : 0]         col;
    for( int i = 0; i < 64; i++ )
      begin
        rom[i] = NO_FIX_POS;
      end
    for( int k = 0; k < 24; k++ )
      begin
        for( int p = 0; p < 6; p++ )
          begin
            col[p] = PARITY_MASK[p][k];
          end
        rom[col] = 5'( k );
      end
    return rom;
  endfunction

  // Syndrome to error bit position.
  localparam logic [63 : 0][4 : 0] ROM_INIT = build_rom();

endpackage

//--- verilog/csi2_rx_header_top.sv
`timescale 1ns/1ps

module csi2_rx_header_top
(
  input                                 clk_i,
  input                                 srst_i,
  input                                 byte_valid_i,
  input        [7 : 0]                  byte_i,
  input                                 pkt_end_i,
  output logic                          hdr_valid_o,
  output logic [1 : 0]                  vc_o,
  output logic [5 : 0]                  dt_o,
  output logic [15 : 0]                 wc_o,
  output logic                          ecc_err_o,
  output logic                          ecc_fixed_o,
  output logic                          pay_valid_o,
  output logic [csi2_pkg::WORD_W-1 : 0] pay_data_o,
  output logic                          pay_last_o
);

logic                          word_valid;
logic [csi2_pkg::WORD_W-1 : 0] word_data;
logic                          pkt_done;

csi2_dec_if dec_if();

csi2_byte_packer packer_i
(
  .clk_i        ( clk_i        ),
  .srst_i       ( srst_i       ),
  .byte_valid_i ( byte_valid_i ),
  .byte_i       ( byte_i       ),
  .pkt_end_i    ( pkt_end_i    ),
  .word_valid_o ( word_valid   ),
  .word_data_o  ( word_data    ),
  .pkt_done_o   ( pkt_done     )
);

csi2_hamming_dec dec_i
(
  .clk_i      ( clk_i      ),
  .srst_i     ( srst_i     ),
  .valid_i    ( word_valid ),
  .data_i     ( word_data  ),
  .pkt_done_i ( pkt_done   ),
  .dec_o      ( dec_if     )
);

csi2_header_parse parse_i
(
  .clk_i       ( clk_i       ),
  .srst_i      ( srst_i      ),
  .dec_i       ( dec_if      ),
  .hdr_valid_o ( hdr_valid_o ),
  .vc_o        ( vc_o        ),
  .dt_o        ( dt_o        ),
  .wc_o        ( wc_o        ),
  .ecc_err_o   ( ecc_err_o   ),
  .ecc_fixed_o ( ecc_fixed_o ),
  .pay_valid_o ( pay_valid_o ),
  .pay_data_o  ( pay_data_o  ),
  .pay_last_o  ( pay_last_o  )
);

endmodule
